/* verilog/cache_pkg.sv */
// cache package with geometry constants, width types and controller states
`default_nettype none

package cache_pkg;

    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;
    localparam int WORD_W   = 32;
    localparam int BANK_NUM = 4;
    localparam int SET_NUM  = 1 << INDEX_W;

    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [OFFSET_W-1:0]         offset_t;
    typedef logic [$clog2(BANK_NUM)-1:0] bank_t;
    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [31:0]                 addr_t;
    typedef logic [3:0]                  lfsr_t;

    localparam lfsr_t      LFSR_SEED    = '1;
    // bridge code for a whole-line read
    localparam logic [2:0] RD_TYPE_LINE = 3'b100;

    typedef enum logic [1:0] {IDLE, LOOKUP, REPLACE, REFILL} ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/cache_ctrl.sv */
// cache controller FSM that sequences accept, lookup, line request and refill
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid,
    input  logic hit,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    input  logic critical_beat,
    output logic addr_ok,
    output logic data_ok,
    output logic rd_req,
    output logic accept,
    output logic miss_start,
    output logic fill_beat,
    output logic fill_done,
    output logic refilling
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (accept)
                begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (!hit)
                begin
                    state_next = REPLACE;
                end
                else if (!accept)
                begin
                    state_next = IDLE;
                end
            end
            REPLACE:
            begin
                if (rd_rdy)
                begin
                    state_next = REFILL;
                end
            end
            REFILL:
            begin
                if (fill_done)
                begin
                    state_next = IDLE;
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    // a hit in lookup frees the request port for the next access
    assign addr_ok    = (state == IDLE) || (state == LOOKUP && hit);
    assign accept     = valid && addr_ok;
    assign miss_start = (state == LOOKUP) && !hit;
    assign refilling  = (state == REFILL);
    assign fill_beat  = refilling && ret_valid;
    assign fill_done  = fill_beat && ret_last;
    assign rd_req     = (state == REPLACE);
    assign data_ok    = (state == LOOKUP && hit) || critical_beat;

endmodule

`default_nettype wire

/* verilog/refill_counter.sv */
// refill beat counter that flags the beat carrying the requested word
`timescale 1ns/1ps
`default_nettype none

module refill_counter import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fill_beat,
    input  logic  fill_done,
    input  bank_t req_bank,
    output bank_t fill_bank,
    output logic  critical_beat
);

    bank_t beat_cnt;

    always_ff @(posedge clk)
    begin
        if (rst || fill_done)
        begin
            beat_cnt <= '0;
        end
        else if (fill_beat)
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beats arrive in word order
    assign fill_bank     = beat_cnt;
    assign critical_beat = fill_beat && (beat_cnt == req_bank);

endmodule

`default_nettype wire

/* verilog/request_buffer.sv */
// request buffer that holds the accepted access and forms the line address
`timescale 1ns/1ps
`default_nettype none

module request_buffer import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  index_t     index,
    input  tag_t       tag,
    input  offset_t    offset,
    output index_t     rb_index,
    output tag_t       rb_tag,
    output bank_t      rb_bank,
    output addr_t      rd_addr,
    output logic [2:0] rd_type
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rb_index <= '0;
            rb_tag   <= '0;
            rb_bank  <= '0;
        end
        else if (accept)
        begin
            rb_index <= index;
            rb_tag   <= tag;
            // word select from the upper offset bits
            rb_bank  <= offset[OFFSET_W-1 -: $bits(bank_t)];
        end
    end

    // line address with the byte offset dropped
    assign rd_addr = {rb_tag, rb_index, {OFFSET_W{1'b0}}};
    assign rd_type = RD_TYPE_LINE;

endmodule

`default_nettype wire

/* verilog/tag_store.sv */
// tag and valid arrays for both ways with hit detection and LFSR victim choice
`timescale 1ns/1ps
`default_nettype none

module tag_store import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   refilling,
    input  logic   miss_start,
    input  logic   fill_done,
    input  index_t index,
    input  index_t rb_index,
    input  tag_t   rb_tag,
    output logic   hit,
    output logic   hit_way,
    output logic   victim_way
);

    tag_t               tag_mem   [2][SET_NUM];
    logic [SET_NUM-1:0] valid_mem [2];
    tag_t               tag_rd    [2];
    logic [1:0]         valid_rd;
    logic [1:0]         way_hit;
    index_t             rd_index;
    lfsr_t              lfsr;

    assign rd_index = refilling ? rb_index : index;

    always_ff @(posedge clk)
    begin
        if (fill_done)
        begin
            tag_mem[victim_way][rb_index] <= rb_tag;
        end
        tag_rd[0] <= tag_mem[0][rd_index];
        tag_rd[1] <= tag_mem[1][rd_index];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_mem[0] <= '0;
            valid_mem[1] <= '0;
            valid_rd     <= '0;
        end
        else
        begin
            if (fill_done)
            begin
                valid_mem[victim_way][rb_index] <= 1'b1;
            end
            valid_rd <= {valid_mem[1][rd_index], valid_mem[0][rd_index]};
        end
    end

    assign way_hit[0] = valid_rd[0] && (tag_rd[0] == rb_tag);
    assign way_hit[1] = valid_rd[1] && (tag_rd[1] == rb_tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    // lfsr advances only on a miss, so the victim follows the miss order
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lfsr       <= LFSR_SEED;
            victim_way <= 1'b0;
        end
        else if (miss_start)
        begin
            victim_way <= lfsr[0];
            lfsr       <= {lfsr[2:0], lfsr[3] ^ lfsr[0]};
        end
    end

endmodule

`default_nettype wire

/* verilog/data_store.sv */
// four-bank data arrays for both ways with refill writes and read-word select
`timescale 1ns/1ps
`default_nettype none

module data_store import cache_pkg::*;
(
    input  logic   clk,
    input  logic   refilling,
    input  logic   fill_beat,
    input  logic   hit_way,
    input  logic   victim_way,
    input  index_t index,
    input  index_t rb_index,
    input  bank_t  rb_bank,
    input  bank_t  fill_bank,
    input  word_t  ret_data,
    output word_t  rdata
);

    word_t  data_mem [2][BANK_NUM][SET_NUM];
    word_t  data_rd  [2][BANK_NUM];
    index_t rd_index;

    assign rd_index = refilling ? rb_index : index;

    // one beat fills one bank of the victim line
    always_ff @(posedge clk)
    begin
        if (fill_beat)
        begin
            data_mem[victim_way][fill_bank][rb_index] <= ret_data;
        end
        for (int w = 0; w < 2; w++)
        begin
            for (int b = 0; b < BANK_NUM; b++)
            begin
                data_rd[w][b] <= data_mem[w][b][rd_index];
            end
        end
    end

    // during refill the word comes straight from the bridge
    assign rdata = refilling ? ret_data : data_rd[hit_way][rb_bank];

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
// read-only two-way cache top level joining controller, counter, buffer and stores
`timescale 1ns/1ps
`default_nettype none

module icache_top import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  index_t     index,
    input  tag_t       tag,
    input  offset_t    offset,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    output logic       rd_req,
    output logic [2:0] rd_type,
    output addr_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data
);

    logic   accept;
    logic   miss_start;
    logic   fill_beat;
    logic   fill_done;
    logic   refilling;
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   critical_beat;
    bank_t  fill_bank;
    bank_t  rb_bank;
    index_t rb_index;
    tag_t   rb_tag;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .hit           (hit),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .critical_beat (critical_beat),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rd_req        (rd_req),
        .accept        (accept),
        .miss_start    (miss_start),
        .fill_beat     (fill_beat),
        .fill_done     (fill_done),
        .refilling     (refilling)
    );

    refill_counter u_refill_counter (
        .clk           (clk),
        .rst           (rst),
        .fill_beat     (fill_beat),
        .fill_done     (fill_done),
        .req_bank      (rb_bank),
        .fill_bank     (fill_bank),
        .critical_beat (critical_beat)
    );

    request_buffer u_request_buffer (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .index    (index),
        .tag      (tag),
        .offset   (offset),
        .rb_index (rb_index),
        .rb_tag   (rb_tag),
        .rb_bank  (rb_bank),
        .rd_addr  (rd_addr),
        .rd_type  (rd_type)
    );

    tag_store u_tag_store (
        .clk        (clk),
        .rst        (rst),
        .refilling  (refilling),
        .miss_start (miss_start),
        .fill_done  (fill_done),
        .index      (index),
        .rb_index   (rb_index),
        .rb_tag     (rb_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    data_store u_data_store (
        .clk        (clk),
        .refilling  (refilling),
        .fill_beat  (fill_beat),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .index      (index),
        .rb_index   (rb_index),
        .rb_bank    (rb_bank),
        .fill_bank  (fill_bank),
        .ret_data   (ret_data),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_icache.sv */
// testbench for the two-way read-only cache with a bridge model and a victim model
`timescale 1ns/1ps
`default_nettype none

module tb_icache import cache_pkg::*;
();

    localparam int    RST_CYCLES = 16;
    localparam int    ROW_NUM    = 20;
    localparam int    TIMEOUT    = 40 * ROW_NUM + RST_CYCLES;
    localparam word_t PATTERN    = 32'h5a3c_96e1;

    // columns are index, tag, offset and expected hit
    localparam logic [32:0] ROWS [ROW_NUM] = '{
        {8'h10, 20'h12345, 4'h0, 1'b0},
        {8'h10, 20'h12345, 4'h4, 1'b1},
        {8'h10, 20'h12345, 4'hc, 1'b1},
        {8'h10, 20'h12345, 4'h8, 1'b1},
        {8'h10, 20'habcde, 4'h8, 1'b0},
        {8'h10, 20'h12345, 4'h4, 1'b1},
        {8'h10, 20'habcde, 4'h0, 1'b1},
        {8'h10, 20'h12345, 4'hc, 1'b1},
        {8'h10, 20'h55555, 4'h4, 1'b0},
        {8'h10, 20'habcde, 4'hc, 1'b1},
        {8'h10, 20'h55555, 4'h0, 1'b1},
        {8'h10, 20'h12345, 4'h8, 1'b0},
        {8'h10, 20'h55555, 4'hc, 1'b1},
        {8'hff, 20'hfffff, 4'h6, 1'b0},
        {8'hff, 20'hfffff, 4'hf, 1'b1},
        {8'h00, 20'h00000, 4'hc, 1'b0},
        {8'h00, 20'h00000, 4'h0, 1'b1},
        {8'h10, 20'habcde, 4'h4, 1'b0},
        {8'h10, 20'h55555, 4'h8, 1'b1},
        {8'h10, 20'habcde, 4'hc, 1'b1}
    };

    logic       clk;
    logic       rst;
    logic       valid;
    index_t     index;
    tag_t       tag;
    offset_t    offset;
    logic       addr_ok;
    logic       data_ok;
    word_t      rdata;
    logic       rd_req;
    logic [2:0] rd_type;
    addr_t      rd_addr;
    logic       rd_rdy;
    logic       ret_valid;
    logic       ret_last;
    word_t      ret_data;

    // two-way tag model and victim lfsr
    tag_t  model_tag   [2][SET_NUM];
    logic  model_valid [2][SET_NUM];
    lfsr_t model_lfsr;

    word_t exp_word_q  [$];
    logic  exp_hit_q   [$];
    int    acc_cycle_q [$];

    int    cycle_cnt;
    int    sample;
    int    row;
    int    cur_row;
    logic  miss_pending;
    logic  req_seen;
    addr_t miss_line;
    logic  prev_req;
    logic  prev_rdy;
    logic  hit_now;
    logic  way;
    word_t got_word;
    logic  got_hit;
    int    got_cycle;

    icache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // memory contents of the bridge side
    function automatic word_t line_word(addr_t byte_addr);
        return byte_addr ^ PATTERN;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal;
    endtask

    task automatic fail_now(string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles waiting for the cache", cycle_cnt);
            abort_run();
        end
    end

    // bridge answers each line request with four beats after a random wait
    initial
    begin : bridge_model
        addr_t line_addr;
        int    wait_left;
        int    beat;
        int    phase;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        line_addr = '0;
        wait_left = 0;
        beat      = 0;
        phase     = 0;
        forever
        begin
            @(negedge clk);
            rd_rdy    = 1'b0;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            case (phase)
                0:
                begin
                    if (rd_req)
                    begin
                        line_addr = rd_addr;
                        wait_left = $urandom % 4;
                        phase     = 1;
                    end
                end
                1:
                begin
                    if (wait_left == 0)
                    begin
                        rd_rdy = 1'b1;
                        beat   = 0;
                        phase  = 2;
                    end
                    else
                    begin
                        wait_left = wait_left - 1;
                    end
                end
                default:
                begin
                    ret_valid = 1'b1;
                    ret_data  = line_word(line_addr + addr_t'(beat * 4));
                    ret_last  = (beat == 3);
                    if (beat == 3)
                    begin
                        phase = 0;
                    end
                    beat = beat + 1;
                end
            endcase
        end
    end

    initial
    begin
        void'($urandom(32'hee8a_f0d6));
        rst          = 1'b1;
        valid        = 1'b0;
        index        = '0;
        tag          = '0;
        offset       = '0;
        model_lfsr   = LFSR_SEED;
        miss_pending = 1'b0;
        req_seen     = 1'b0;
        miss_line    = '0;
        prev_req     = 1'b0;
        prev_rdy     = 1'b0;
        for (int s = 0; s < SET_NUM; s++)
        begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        @(negedge clk);
        #1;
        check_value("data_ok", 32'(data_ok), 32'(0));
        check_value("rd_req", 32'(rd_req), 32'(0));

        row    = 0;
        sample = 0;
        while (row < ROW_NUM || exp_word_q.size() > 0)
        begin
            @(negedge clk);
            cur_row = row;
            if (row < ROW_NUM)
            begin
                valid  = 1'b1;
                index  = ROWS[row][32:25];
                tag    = ROWS[row][24:5];
                offset = ROWS[row][4:1];
            end
            else
            begin
                valid = 1'b0;
            end
            #1;
            sample = sample + 1;
            if (sample == 1)
            begin
                check_value("addr_ok", 32'(addr_ok), 32'(1));
            end

            if (rd_req)
            begin
                if (!miss_pending)
                begin
                    fail_now("line request seen while no miss was outstanding");
                end
                check_value("rd_addr", rd_addr, miss_line);
                check_value("rd_type", 32'(rd_type), 32'(RD_TYPE_LINE));
                check_value("addr_ok", 32'(addr_ok), 32'(0));
                req_seen = 1'b1;
            end
            if (prev_req && !prev_rdy)
            begin
                check_value("rd_req", 32'(rd_req), 32'(1));
            end
            prev_req = rd_req;
            prev_rdy = rd_rdy;

            if (data_ok)
            begin
                if (exp_word_q.size() == 0)
                begin
                    fail_now("data_ok pulsed with no request outstanding");
                end
                got_word  = exp_word_q.pop_front();
                got_hit   = exp_hit_q.pop_front();
                got_cycle = acc_cycle_q.pop_front();
                check_value("rdata", rdata, got_word);
                if (got_hit)
                begin
                    check_value("data_ok cycle", 32'(sample), 32'(got_cycle + 1));
                end
                else
                begin
                    if (!req_seen)
                    begin
                        fail_now("miss returned data without a line request");
                    end
                    miss_pending = 1'b0;
                end
            end

            if (valid && addr_ok)
            begin
                hit_now = (model_valid[0][index] && model_tag[0][index] == tag) ||
                          (model_valid[1][index] && model_tag[1][index] == tag);
                check_value("table hit", 32'(hit_now), 32'(ROWS[cur_row][0]));
                exp_word_q.push_back(line_word({tag, index, offset[3:2], 2'b00}));
                exp_hit_q.push_back(hit_now);
                acc_cycle_q.push_back(sample);
                if (!hit_now)
                begin
                    miss_pending = 1'b1;
                    req_seen     = 1'b0;
                    miss_line    = {tag, index, 4'h0};
                    way          = model_lfsr[0];
                    model_tag[way][index]   = tag;
                    model_valid[way][index] = 1'b1;
                    model_lfsr = {model_lfsr[2:0], model_lfsr[3] ^ model_lfsr[0]};
                end
                row = row + 1;
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/refill_counter.sv
verilog/request_buffer.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/icache_top.sv
testbench/tb_icache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_icache -f list.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_icache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
